/* tester_pkg.sv */
package tester_pkg;

	////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////

	localparam int VEC_W = 16;
	localparam int VEC_BYTES = 2;
	localparam int CFG_BYTES = 3;
	localparam int STORE_DEPTH = 8;
	localparam int STORE_PTR_W = $clog2(STORE_DEPTH + 1);
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_W = $clog2(CLKS_PER_BIT);

	typedef logic [VEC_W-1:0] vec_t;
	typedef logic [7:0] byte_t;
	typedef logic [7:0] edge_t;
	typedef logic [STORE_PTR_W-1:0] store_ptr_t;
	typedef logic [BAUD_W-1:0] baud_cnt_t;

	// Baud divider wrap point and mid-bit sample point.
	localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
	localparam baud_cnt_t BAUD_MID = baud_cnt_t'(CLKS_PER_BIT / 2);

	////////////////////////////////////////////////////////////
	// Host protocol codes
	////////////////////////////////////////////////////////////

	localparam byte_t CMD_INPUT = 8'h49;
	localparam byte_t CMD_CONFIG = 8'h43;
	localparam byte_t CMD_EXECUTE = 8'h45;

	localparam byte_t RSP_ACK = 8'h06;
	localparam byte_t RSP_UNKNOWN = 8'h3F;
	localparam byte_t RSP_NO_VECTORS = 8'h15;

	// Cycle timing in force until the host sends a configuration.
	localparam edge_t DEF_LEAD = 8'd0;
	localparam edge_t DEF_TRAIL = 8'd1;
	localparam edge_t DEF_LEN = 8'd3;

	typedef enum logic [3:0] {
		ST_IDLE, ST_DECODE, ST_HDR_ACK, ST_COLLECT, ST_STORE, ST_CONFIG,
		ST_EXEC_START, ST_EXEC_WAIT, ST_CLEAR, ST_TX_START, ST_TX_WAIT
	} fsm_state_t;

endpackage

/* test_ctrl_if.sv */
`timescale 1ns/100ps

interface test_ctrl_if;
	import tester_pkg::*;

	// Run request and the cycle timing it uses.
	logic start;
	edge_t lead_edge;
	edge_t trail_edge;
	edge_t cycle_len;

	// End of run, one clock wide.
	logic done;

	modport cmd (output start, lead_edge, trail_edge, cycle_len, input done);
	modport seq (input start, lead_edge, trail_edge, cycle_len, output done);

endinterface

/* uart_link.sv */
`timescale 1ns/100ps

interface uart_if;
	import tester_pkg::*;

	logic rx_valid;
	byte_t rx_byte;
	logic rx_taken;
	logic tx_start;
	byte_t tx_byte;
	logic tx_busy;

	modport link (output rx_valid, rx_byte, tx_busy, input rx_taken, tx_start, tx_byte);
	modport ctrl (input rx_valid, rx_byte, tx_busy, output rx_taken, tx_start, tx_byte);

endinterface

module uart_link (
	input  logic CLK,
	input  logic rst,
	input  logic rx,
	output logic tx,
	uart_if.link bus
);
	import tester_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic rx_active;
	baud_cnt_t rx_div;
	logic [3:0] rx_idx;
	byte_t rx_shift;
	logic rx_sample;
	baud_cnt_t tx_div;
	logic [3:0] tx_idx;
	logic [9:0] tx_shift;

	////////////////////////////////////////////////////////////
	// Receiver
	////////////////////////////////////////////////////////////

	// Index 0 is the start bit, 1 to 8 the data, 9 the stop bit.
	assign rx_sample = rx_active && (rx_div == BAUD_MID);

	always_ff @(posedge CLK) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_active <= 1'b0;
			rx_div <= '0;
			rx_idx <= '0;
			bus.rx_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			if (bus.rx_taken) begin
				bus.rx_valid <= 1'b0;
			end
			if (!rx_active) begin
				if (!rx_sync) begin
					rx_active <= 1'b1;
					rx_div <= '0;
					rx_idx <= '0;
				end
			end else begin
				rx_div <= (rx_div == BAUD_LAST) ? '0 : rx_div + 1'b1;
				if (rx_sample) begin
					rx_idx <= rx_idx + 4'd1;
					if (rx_idx == 4'd0 && rx_sync) begin
						// Glitch, not a real start bit.
						rx_active <= 1'b0;
					end else if (rx_idx == 4'd9) begin
						rx_active <= 1'b0;
						if (rx_sync && !bus.rx_valid) begin
							bus.rx_valid <= 1'b1;
						end
					end
				end
			end
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge CLK) begin
		if (rx_sample && rx_idx != 4'd0 && rx_idx != 4'd9) begin
			rx_shift <= {rx_sync, rx_shift[7:1]};
		end
		if (rx_sample && rx_idx == 4'd9 && !bus.rx_valid) begin
			bus.rx_byte <= rx_shift;
		end
	end

	////////////////////////////////////////////////////////////
	// Transmitter
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			bus.tx_busy <= 1'b0;
			tx_div <= '0;
			tx_idx <= '0;
		end else if (!bus.tx_busy) begin
			bus.tx_busy <= bus.tx_start;
			tx_div <= '0;
			tx_idx <= '0;
		end else if (tx_div == BAUD_LAST) begin
			tx_div <= '0;
			if (tx_idx == 4'd9) begin
				bus.tx_busy <= 1'b0;
			end else begin
				tx_idx <= tx_idx + 4'd1;
			end
		end else begin
			tx_div <= tx_div + 1'b1;
		end
	end

	// Frame is stop, data, start, shifted out from bit 0.
	always_ff @(posedge CLK) begin
		if (bus.tx_start && !bus.tx_busy) begin
			tx_shift <= {1'b1, bus.tx_byte, 1'b0};
		end else if (bus.tx_busy && tx_div == BAUD_LAST) begin
			tx_shift <= {1'b1, tx_shift[9:1]};
		end
	end

	assign tx = bus.tx_busy ? tx_shift[0] : 1'b1;

	a_tx_start_idle: assert property (@(posedge CLK) disable iff (rst)
		bus.tx_start |-> !bus.tx_busy);

endmodule

/* vector_store.sv */
`timescale 1ns/100ps

module vector_store (
	input  logic CLK,
	input  logic rst,
	input  logic wr_en,
	input  tester_pkg::vec_t wr_data,
	input  logic clear,
	input  logic rd_next,
	output tester_pkg::vec_t rd_data,
	output logic more,
	output logic empty
);
	import tester_pkg::*;

	localparam int IDX_W = $clog2(STORE_DEPTH);

	vec_t mem [STORE_DEPTH];
	store_ptr_t wr_ptr;
	store_ptr_t rd_ptr;

	// Pointers count entries, so a full store reads STORE_DEPTH.
	always_ff @(posedge CLK) begin
		if (rst || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_next && more) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_ptr[IDX_W-1:0]] <= wr_data;
		end
	end

	assign rd_data = mem[rd_ptr[IDX_W-1:0]];
	assign more = (rd_ptr < wr_ptr);
	assign empty = (wr_ptr == '0);

	a_no_overfill: assert property (@(posedge CLK) disable iff (rst)
		wr_en |-> (wr_ptr < store_ptr_t'(STORE_DEPTH)));

endmodule

/* command_fsm.sv */
`timescale 1ns/100ps

module command_fsm (
	input  logic CLK,
	input  logic rst,
	uart_if.ctrl uart,
	test_ctrl_if.cmd test,
	output logic wr_en,
	output tester_pkg::vec_t wr_data,
	output logic clear,
	input  logic empty
);
	import tester_pkg::*;

	fsm_state_t state;
	fsm_state_t ret_state;
	byte_t cmd;
	byte_t rsp;
	logic [1:0] byte_cnt;
	logic [1:0] last_byte;
	logic [CFG_BYTES*8-1:0] asm_reg;

	// Bytes fill the assembly register from the top down.
	assign last_byte = (cmd == CMD_INPUT) ? 2'(VEC_BYTES - 1) : 2'(CFG_BYTES - 1);
	assign wr_data = asm_reg[CFG_BYTES*8-1 -: VEC_W];

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= ST_IDLE;
			ret_state <= ST_IDLE;
			byte_cnt <= '0;
			test.lead_edge <= DEF_LEAD;
			test.trail_edge <= DEF_TRAIL;
			test.cycle_len <= DEF_LEN;
		end else begin
			case (state)
				ST_IDLE: begin
					if (uart.rx_valid) begin
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					ret_state <= ST_IDLE;
					if (cmd == CMD_INPUT || cmd == CMD_CONFIG) begin
						state <= ST_HDR_ACK;
					end else if (cmd == CMD_EXECUTE) begin
						state <= empty ? ST_TX_START : ST_EXEC_START;
					end else begin
						state <= ST_TX_START;
					end
				end
				ST_HDR_ACK: begin
					byte_cnt <= '0;
					ret_state <= ST_COLLECT;
					state <= ST_TX_START;
				end
				ST_COLLECT: begin
					if (uart.rx_valid) begin
						byte_cnt <= byte_cnt + 2'd1;
						if (byte_cnt == last_byte) begin
							state <= (cmd == CMD_INPUT) ? ST_STORE : ST_CONFIG;
						end
					end
				end
				ST_STORE: begin
					ret_state <= ST_IDLE;
					state <= ST_TX_START;
				end
				ST_CONFIG: begin
					test.lead_edge <= asm_reg[7:0];
					test.trail_edge <= asm_reg[15:8];
					test.cycle_len <= asm_reg[23:16];
					ret_state <= ST_IDLE;
					state <= ST_TX_START;
				end
				ST_EXEC_START: state <= ST_EXEC_WAIT;
				ST_EXEC_WAIT: begin
					if (test.done) begin
						state <= ST_CLEAR;
					end
				end
				ST_CLEAR: state <= ST_TX_START;
				ST_TX_START: begin
					if (!uart.tx_busy) begin
						state <= ST_TX_WAIT;
					end
				end
				// Busy is already high on entry here.
				ST_TX_WAIT: begin
					if (!uart.tx_busy) begin
						state <= ret_state;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Command byte, data assembly and response byte.
	always_ff @(posedge CLK) begin
		if (state == ST_IDLE && uart.rx_valid) begin
			cmd <= uart.rx_byte;
		end
		if (state == ST_COLLECT && uart.rx_valid) begin
			asm_reg <= {uart.rx_byte, asm_reg[CFG_BYTES*8-1:8]};
		end
		if (state == ST_DECODE) begin
			if (cmd == CMD_EXECUTE) begin
				rsp <= RSP_NO_VECTORS;
			end else if (cmd == CMD_INPUT || cmd == CMD_CONFIG) begin
				rsp <= RSP_ACK;
			end else begin
				rsp <= RSP_UNKNOWN;
			end
		end else if (state == ST_STORE || state == ST_CONFIG || state == ST_CLEAR) begin
			rsp <= RSP_ACK;
		end
	end

	assign uart.rx_taken = uart.rx_valid && (state == ST_IDLE || state == ST_COLLECT);
	assign uart.tx_start = (state == ST_TX_START) && !uart.tx_busy;
	assign uart.tx_byte = rsp;
	assign test.start = (state == ST_EXEC_START);
	assign wr_en = (state == ST_STORE);
	assign clear = (state == ST_CLEAR);

endmodule

/* test_sequencer.sv */
`timescale 1ns/100ps

module test_sequencer (
	input  logic CLK,
	input  logic rst,
	test_ctrl_if.seq ctrl,
	input  tester_pkg::vec_t rd_data,
	input  logic more,
	output logic rd_next,
	output tester_pkg::vec_t signals,
	output logic cs_bar,
	output logic counter_clk,
	output logic counter_rst
);
	import tester_pkg::*;

	logic active;
	edge_t cnt;
	logic cycle_end;
	logic in_window;

	assign cycle_end = active && (cnt == ctrl.cycle_len);

	// Chip select window spans trail minus lead counts.
	assign in_window = active && (cnt >= ctrl.lead_edge) && (cnt < ctrl.trail_edge);

	// First clock of each cycle fetches the next vector.
	assign rd_next = active && (cnt == '0);

	////////////////////////////////////////////////////////////
	// Cycle counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			active <= 1'b0;
			cnt <= '0;
			ctrl.done <= 1'b0;
		end else begin
			ctrl.done <= 1'b0;
			if (ctrl.start) begin
				active <= 1'b1;
				cnt <= '0;
			end else if (cycle_end) begin
				cnt <= '0;
				if (!more) begin
					active <= 1'b0;
					ctrl.done <= 1'b1;
				end
			end else if (active) begin
				cnt <= cnt + 8'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs to the DUT and the SRAM board
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			signals <= '0;
			cs_bar <= 1'b1;
			counter_clk <= 1'b0;
			counter_rst <= 1'b0;
		end else begin
			if (rd_next) begin
				signals <= rd_data;
			end
			cs_bar <= !in_window;
			// High through the last count of the cycle.
			counter_clk <= cycle_end;
			counter_rst <= ctrl.start;
		end
	end

	a_edges_ordered: assert property (@(posedge CLK) disable iff (rst)
		ctrl.start |-> (ctrl.lead_edge < ctrl.trail_edge) &&
			(ctrl.trail_edge <= ctrl.cycle_len));

endmodule

/* pattern_tester.sv */
`timescale 1ns/100ps

module pattern_tester (
	input  logic CLK,
	input  logic rst,
	input  logic rx,
	output logic tx,
	output tester_pkg::vec_t signals,
	output logic cs_bar,
	output logic counter_clk,
	output logic counter_rst
);
	import tester_pkg::*;

	logic wr_en;
	vec_t wr_data;
	logic clear;
	logic rd_next;
	vec_t rd_data;
	logic more;
	logic empty;

	uart_if uart_bus ();
	test_ctrl_if test_bus ();

	uart_link u_link (.CLK(CLK), .rst(rst), .rx(rx), .tx(tx), .bus(uart_bus.link));

	vector_store u_store (
		.CLK(CLK), .rst(rst), .wr_en(wr_en), .wr_data(wr_data), .clear(clear),
		.rd_next(rd_next), .rd_data(rd_data), .more(more), .empty(empty)
	);

	command_fsm u_fsm (
		.CLK(CLK), .rst(rst), .uart(uart_bus.ctrl), .test(test_bus.cmd),
		.wr_en(wr_en), .wr_data(wr_data), .clear(clear), .empty(empty)
	);

	test_sequencer u_seq (
		.CLK(CLK), .rst(rst), .ctrl(test_bus.seq), .rd_data(rd_data), .more(more),
		.rd_next(rd_next), .signals(signals), .cs_bar(cs_bar),
		.counter_clk(counter_clk), .counter_rst(counter_rst)
	);

endmodule

/* tb_pattern_tester.sv */
`timescale 1ns/100ps

module tb_pattern_tester;
	import tester_pkg::*;

	localparam int MAX_CASES = 32;
	localparam int REC_BYTES = 6;

	logic CLK;
	logic rst;
	logic rx;
	logic tx;
	vec_t signals;
	logic cs_bar;
	logic counter_clk;
	logic counter_rst;

	// One record per case: cmd, three data bytes, two expected responses.
	byte_t cases_mem [MAX_CASES*REC_BYTES];
	byte_t rsp_q [$];
	vec_t store_q [$];
	vec_t run_vecs [$];
	int run_lead;
	int run_trail;
	int run_len;
	int mismatch_cnt = 0;
	int fail_cnt = 0;
	int cycles = 0;
	int timeout_cycles = 0;
	int rst_pulses = 0;
	int applied_total = 0;
	logic mon_active = 1'b0;
	int mon_idx;
	int mon_pos;
	int mon_low;
	int mon_strobes;

	pattern_tester u_dut (
		.CLK(CLK), .rst(rst), .rx(rx), .tx(tx), .signals(signals), .cs_bar(cs_bar),
		.counter_clk(counter_clk), .counter_rst(counter_rst)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic report_counts;
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
	endtask

	task automatic idle_gap;
		repeat ($urandom_range(12, 1)) @(posedge CLK);
	endtask

	// 8N1 frame, each bit held CLKS_PER_BIT clocks.
	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge CLK);
			#1;
			rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge CLK);
		end
	endtask

	task automatic wait_response(input byte_t exp);
		byte_t got;
		while (rsp_q.size() == 0) @(posedge CLK);
		got = rsp_q.pop_front();
		assert (got == exp) else begin
			$display("MISMATCH response byte: got %h expected %h", got, exp);
			mismatch_cnt++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host serial receiver and output monitor
	////////////////////////////////////////////////////////////

	initial begin : host_rx
		byte_t b;
		int i;
		forever begin
			@(posedge CLK);
			if (!rst && tx == 1'b0) begin
				// Move to the middle of the start bit.
				repeat (CLKS_PER_BIT / 2) @(posedge CLK);
				for (i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(posedge CLK);
					b[i] = tx;
				end
				repeat (CLKS_PER_BIT) @(posedge CLK);
				assert (tx == 1'b1) else begin
					$display("Stop bit missing on tx");
					fail_cnt++;
				end
				rsp_q.push_back(b);
			end
		end
	end

	// Window position p shows the outputs for cycle count p.
	always @(posedge CLK) begin
		if (!rst) begin
			if (counter_rst) begin
				rst_pulses++;
				assert (!mon_active) else begin
					$display("counter_rst pulsed in the middle of a test run");
					fail_cnt++;
				end
				mon_active = 1'b1;
				mon_idx = 0;
				mon_pos = 0;
				mon_low = 0;
				mon_strobes = 0;
			end else if (mon_active) begin
				assert (signals == run_vecs[mon_idx]) else begin
					$display("MISMATCH signals vector %0d: got %h expected %h",
						mon_idx, signals, run_vecs[mon_idx]);
					mismatch_cnt++;
				end
				if (!cs_bar) mon_low++;
				if (counter_clk) mon_strobes++;
				if (mon_pos == run_len) begin
					assert (mon_low == run_trail - run_lead) else begin
						$display("MISMATCH cs_bar low clocks: got %h expected %h",
							mon_low, run_trail - run_lead);
						mismatch_cnt++;
					end
					// The strobe belongs on the last clock of the cycle.
					assert (counter_clk) else begin
						$display("MISMATCH counter_clk at cycle end: got %h expected %h",
							counter_clk, 1'b1);
						mismatch_cnt++;
					end
					assert (mon_strobes == 1) else begin
						$display("MISMATCH counter_clk pulses: got %h expected %h", mon_strobes, 1);
						mismatch_cnt++;
					end
					applied_total++;
					mon_idx++;
					mon_pos = 0;
					mon_low = 0;
					mon_strobes = 0;
					if (mon_idx >= run_vecs.size()) mon_active = 1'b0;
				end else begin
					mon_pos++;
				end
			end else begin
				assert (cs_bar && !counter_clk) else begin
					$display("cs_bar or counter_clk active outside a test run");
					fail_cnt++;
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("Timeout after %0d cycles without finishing the cases", cycles);
			report_counts();
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Case replay
	////////////////////////////////////////////////////////////

	initial begin : main
		byte_t cmd;
		int c;
		int base;
		int len;
		int exp_runs;
		int applied_before;
		int cur_lead;
		int cur_trail;
		int cur_len;
		logic ran;
		void'($urandom(32'hd92c_175c));
		rx = 1'b1;
		rst = 1'b1;
		exp_runs = 0;
		$readmemh("pattern_cases.txt", cases_mem);
		// Budget each case, plus a full store of cycles per execute.
		len = int'(DEF_LEN);
		timeout_cycles = 100;
		for (c = 0; c < MAX_CASES; c++) begin
			base = c * REC_BYTES;
			if (cases_mem[base] == 8'hFF) break;
			timeout_cycles += 30 * 10 * CLKS_PER_BIT;
			if (cases_mem[base] == CMD_CONFIG) len = int'(cases_mem[base+3]);
			if (cases_mem[base] == CMD_EXECUTE) timeout_cycles += (len + 1) * STORE_DEPTH;
		end
		repeat (3) @(posedge CLK);
		#1;
		rst = 1'b0;
		assert (signals == '0) else begin
			$display("MISMATCH signals after reset: got %h expected %h", signals, 16'h0);
			mismatch_cnt++;
		end
		cur_lead = int'(DEF_LEAD);
		cur_trail = int'(DEF_TRAIL);
		cur_len = int'(DEF_LEN);
		for (c = 0; c < MAX_CASES; c++) begin
			base = c * REC_BYTES;
			cmd = cases_mem[base];
			if (cmd == 8'hFF) break;
			idle_gap();
			if (cmd == CMD_INPUT || cmd == CMD_CONFIG) begin
				send_byte(cmd);
				wait_response(cases_mem[base+4]);
				idle_gap();
				send_byte(cases_mem[base+1]);
				idle_gap();
				send_byte(cases_mem[base+2]);
				if (cmd == CMD_CONFIG) begin
					idle_gap();
					send_byte(cases_mem[base+3]);
					cur_lead = int'(cases_mem[base+1]);
					cur_trail = int'(cases_mem[base+2]);
					cur_len = int'(cases_mem[base+3]);
				end else begin
					store_q.push_back({cases_mem[base+2], cases_mem[base+1]});
				end
				wait_response(cases_mem[base+5]);
			end else begin
				ran = (cmd == CMD_EXECUTE) && (store_q.size() > 0);
				if (ran) begin
					run_vecs = store_q;
					run_lead = cur_lead;
					run_trail = cur_trail;
					run_len = cur_len;
					store_q.delete();
					exp_runs++;
				end
				applied_before = applied_total;
				send_byte(cmd);
				wait_response(cases_mem[base+4]);
				if (ran) begin
					assert (applied_total == applied_before + run_vecs.size()) else begin
						$display("MISMATCH vectors applied: got %h expected %h",
							applied_total - applied_before, run_vecs.size());
						mismatch_cnt++;
					end
				end
			end
		end
		// Let any stray response byte arrive before the final checks.
		repeat (20 * CLKS_PER_BIT) @(posedge CLK);
		assert (rsp_q.size() == 0) else begin
			$display("Extra response bytes arrived after the last case");
			fail_cnt++;
		end
		assert (rst_pulses == exp_runs) else begin
			$display("MISMATCH counter_rst pulses: got %h expected %h", rst_pulses, exp_runs);
			mismatch_cnt++;
		end
		report_counts();
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* pattern_cases.txt */
// cmd d0 d1 d2 rsp0 rsp1 : command byte, up to three data bytes, expected responses
// Unused bytes are 00; config data is lead, trail, length; cmd FF ends the list.
45 00 00 00 15 00
5A 00 00 00 3F 00
43 01 04 05 06 06
49 34 12 00 06 06
49 CD AB 00 06 06
49 0F F0 00 06 06
45 00 00 00 06 00
45 00 00 00 15 00
43 02 03 03 06 06
49 55 AA 00 06 06
49 A5 5A 00 06 06
45 00 00 00 06 00
FF 00 00 00 00 00

/* flist.f */
tester_pkg.sv
test_ctrl_if.sv
uart_link.sv
vector_store.sv
command_fsm.sv
test_sequencer.sv
pattern_tester.sv
tb_pattern_tester.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the pattern tester testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
	--top-module tb_pattern_tester -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0
